//--- common/flash_pkg.sv
package flash_pkg;

    localparam logic [7:0] READ_OPCODE = 8'h03;   // plain read, one bit per clock

    localparam int CMD_BITS = 32;                  // opcode byte plus 24-bit address
    localparam int CMD_CNT_W = $clog2(CMD_BITS);

    localparam int IMAGE_W = 3;
    localparam int PAGE_W = 12;
    localparam int OFFSET_W = 7;                   // 128 bytes per page

    typedef logic [IMAGE_W-1:0] image_t;
    typedef logic [PAGE_W-1:0] page_t;

    localparam page_t BOOT_PAGE = 12'h805;         // bootloader occupies 805h..808h

    // byte address layout of one image in the flash
    typedef struct packed {
        logic [1:0]          pad;                  // always zero
        image_t              image;
        page_t               page;
        logic [OFFSET_W-1:0] offset;
    } flash_addr_t;

    typedef struct packed {
        logic cs_n;
        logic sck;
        logic mosi;
    } spi_pins_t;

endpackage

//--- common/bubble_pkg.sv
package bubble_pkg;

    typedef enum logic [0:0] {
        LOAD_BOOT = 1'b0,
        LOAD_PAGE = 1'b1
    } load_kind_t;

    typedef struct packed {
        load_kind_t         kind;
        flash_pkg::image_t  image;
        flash_pkg::page_t   page;                  // ignored for a boot load
    } load_req_t;

    localparam int BUF_AW = 15;

    typedef logic [BUF_AW-1:0] buf_addr_t;

    // one bit into the bubble output buffer
    typedef struct packed {
        logic      en;
        buf_addr_t addr;
        logic      data;
    } buf_wr_t;

    localparam buf_addr_t BOOT_BUF_BASE = 15'd4106;
    localparam buf_addr_t PAGE_BUF_BASE = 15'd14336;

    localparam int BOOT_BITS = 2656;
    localparam int MAP_BITS = 1200;                // error map, follows the bootloader
    localparam int PREAMBLE_BITS = 6;
    localparam int PAGE_BITS = 1030;

    localparam int MAP_DEPTH = 4096;
    localparam int MAP_AW = $clog2(MAP_DEPTH);

    // largest section is the bootloader
    localparam int BIT_CNT_W = $clog2(BOOT_BITS);

    typedef logic [MAP_AW-1:0] map_addr_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

endpackage

//--- spi/spi_flash_reader.sv
`timescale 1ns/1ps

module spi_flash_reader (
    input  logic                  MCLK,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  stop,
    input  flash_pkg::flash_addr_t addr,
    input  logic                  bit_req,
    output logic                  bit_valid,
    output logic                  bit_data,
    output flash_pkg::spi_pins_t  spi,
    input  logic                  miso
);
    import flash_pkg::*;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_CMD_LO,
        RD_CMD_HI,
        RD_WAIT,
        RD_DAT_LO,
        RD_DAT_HI
    } rd_state_t;

    rd_state_t            state;
    logic [CMD_BITS-1:0]  cmd_word;
    logic [CMD_BITS-1:0]  shift_q;                 // remaining command bits, msb next
    logic [CMD_CNT_W-1:0] cnt_q;

    assign cmd_word = {READ_OPCODE, addr};

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            state <= RD_IDLE;
            cnt_q <= '0;
            bit_valid <= 1'b0;
            spi <= '{cs_n: 1'b1, sck: 1'b1, mosi: 1'b0};
        end
        else
        begin
            bit_valid <= 1'b0;
            if (stop)
            begin
                spi.cs_n <= 1'b1;
                spi.sck <= 1'b1;
                state <= RD_IDLE;
            end
            else
            begin
                case (state)
                    RD_IDLE:
                        if (start)
                        begin
                            spi.cs_n <= 1'b0;
                            spi.sck <= 1'b0;
                            spi.mosi <= cmd_word[CMD_BITS-1];
                            cnt_q <= '0;
                            state <= RD_CMD_LO;
                        end
                    RD_CMD_LO:
                    begin
                        spi.sck <= 1'b1;                // flash latches mosi here
                        state <= RD_CMD_HI;
                    end
                    RD_CMD_HI:
                        if (cnt_q == CMD_CNT_W'(CMD_BITS - 1))
                            state <= RD_WAIT;
                        else
                        begin
                            spi.sck <= 1'b0;
                            spi.mosi <= shift_q[CMD_BITS-1];
                            cnt_q <= cnt_q + 1'b1;
                            state <= RD_CMD_LO;
                        end
                    RD_WAIT:
                        if (bit_req && !bit_valid)      // skip the cycle that delivers a bit
                        begin
                            spi.sck <= 1'b0;
                            state <= RD_DAT_LO;
                        end
                    RD_DAT_LO:
                    begin
                        spi.sck <= 1'b1;
                        state <= RD_DAT_HI;
                    end
                    RD_DAT_HI:
                    begin
                        bit_valid <= 1'b1;
                        state <= RD_WAIT;
                    end
                    default:
                        state <= RD_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (state == RD_IDLE && start)
            shift_q <= {cmd_word[CMD_BITS-2:0], 1'b0};
        else if (state == RD_CMD_HI)
            shift_q <= shift_q << 1;
        if (state == RD_DAT_HI)
            bit_data <= miso;                          // sampled while sck is high
    end

endmodule

//--- design/bad_loop_map.sv
`timescale 1ns/1ps

module bad_loop_map (
    input  logic MCLK,
    input  logic clear,
    input  logic wr_en,
    input  logic wr_data,
    input  logic rd_en,
    output logic rd_data
);
    import bubble_pkg::*;

    logic      map_q [MAP_DEPTH];
    map_addr_t addr_cnt;
    map_addr_t wr_addr;

    // error map arrives with each 16-entry group reversed
    assign wr_addr = {addr_cnt[MAP_AW-1:4], ~addr_cnt[3:0]};

    always_ff @(posedge MCLK)
    begin
        if (clear)
            addr_cnt <= '0;
        else if (wr_en || rd_en)
            addr_cnt <= addr_cnt + 1'b1;
    end

    always_ff @(posedge MCLK)
    begin
        if (wr_en)
            map_q[wr_addr] <= wr_data;
    end

    always_ff @(posedge MCLK)
    begin
        if (rd_en)
            rd_data <= map_q[addr_cnt];                // held until the next read
    end

endmodule

//--- design/load_sequencer.sv
`timescale 1ns/1ps

module load_sequencer (
    input  logic                    MCLK,
    input  logic                    rst_n,
    input  logic                    req,
    input  bubble_pkg::load_req_t   request,
    output logic                    ack,
    output logic                    rd_start,
    output logic                    rd_stop,
    output flash_pkg::flash_addr_t  rd_addr,
    output logic                    bit_req,
    input  logic                    bit_valid,
    input  logic                    bit_data,
    output logic                    map_clear,
    output logic                    map_wr_en,
    output logic                    map_wr_data,
    output logic                    map_rd_en,
    input  logic                    map_rd_data,
    output bubble_pkg::buf_wr_t     buf_wr
);
    import flash_pkg::*;
    import bubble_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_BOOT,
        S_PG_START,
        S_PG_WAIT,
        S_PG_EVAL,
        S_PG_BIT,
        S_FINISH,
        S_ACK
    } seq_state_t;

    seq_state_t state;
    bit_cnt_t   cnt;
    logic       stage2;                            // error map in a boot, data in a page
    buf_addr_t  addr_q;
    logic       last_bit;

    assign last_bit = (state == S_BOOT && stage2 && cnt == bit_cnt_t'(MAP_BITS - 1)) ||
                      (state == S_PG_BIT && cnt == bit_cnt_t'(PAGE_BITS - 1));

    // cs_n goes high together with the final buffer write
    assign rd_stop = bit_valid && last_bit;

    assign map_wr_data = buf_wr.data;

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
            ack <= 1'b0;
            rd_start <= 1'b0;
            bit_req <= 1'b0;
            map_clear <= 1'b0;
            map_wr_en <= 1'b0;
            map_rd_en <= 1'b0;
            buf_wr <= '0;
            cnt <= '0;
            stage2 <= 1'b0;
            addr_q <= '0;
        end
        else
        begin
            rd_start <= 1'b0;
            map_clear <= 1'b0;
            map_wr_en <= 1'b0;
            map_rd_en <= 1'b0;
            buf_wr.en <= 1'b0;
            case (state)
                S_IDLE:
                    if (req)
                    begin
                        map_clear <= 1'b1;
                        rd_start <= 1'b1;
                        cnt <= '0;
                        stage2 <= 1'b0;
                        if (request.kind == LOAD_BOOT)
                        begin
                            addr_q <= BOOT_BUF_BASE;
                            bit_req <= 1'b1;           // reader waits out the command
                            state <= S_BOOT;
                        end
                        else
                        begin
                            addr_q <= PAGE_BUF_BASE;
                            state <= S_PG_START;
                        end
                    end
                S_BOOT:
                    if (bit_valid)
                    begin
                        buf_wr <= '{en: 1'b1, addr: addr_q, data: bit_data};
                        addr_q <= addr_q + 1'b1;
                        map_wr_en <= stage2;
                        if (last_bit)
                        begin
                            bit_req <= 1'b0;
                            state <= S_FINISH;
                        end
                        else if (!stage2 && cnt == bit_cnt_t'(BOOT_BITS - 1))
                        begin
                            stage2 <= 1'b1;
                            cnt <= '0;
                        end
                        else
                            cnt <= cnt + 1'b1;
                    end
                S_PG_START:
                begin
                    map_rd_en <= 1'b1;                 // table counter cleared by now
                    state <= S_PG_WAIT;
                end
                S_PG_WAIT:
                    state <= S_PG_EVAL;
                S_PG_EVAL:
                    if (stage2 && map_rd_data)
                    begin
                        bit_req <= 1'b1;
                        map_rd_en <= 1'b1;             // prefetch the next entry
                        state <= S_PG_BIT;
                    end
                    else
                    begin
                        // bad loop writes 0, good preamble entry writes 1
                        buf_wr <= '{en: 1'b1, addr: addr_q, data: map_rd_data};
                        addr_q <= addr_q + 1'b1;
                        map_rd_en <= 1'b1;
                        state <= S_PG_WAIT;
                        if (map_rd_data)
                        begin
                            if (cnt == bit_cnt_t'(PREAMBLE_BITS - 1))
                            begin
                                stage2 <= 1'b1;
                                cnt <= '0;
                            end
                            else
                                cnt <= cnt + 1'b1;
                        end
                    end
                S_PG_BIT:
                    if (bit_valid)
                    begin
                        buf_wr <= '{en: 1'b1, addr: addr_q, data: bit_data};
                        addr_q <= addr_q + 1'b1;
                        if (last_bit)
                        begin
                            bit_req <= 1'b0;
                            state <= S_FINISH;
                        end
                        else
                        begin
                            cnt <= cnt + 1'b1;
                            if (map_rd_data)
                                map_rd_en <= 1'b1;     // next loop good, keep streaming
                            else
                            begin
                                bit_req <= 1'b0;
                                state <= S_PG_WAIT;    // spaces the zero write
                            end
                        end
                    end
                S_FINISH:
                begin
                    ack <= 1'b1;
                    state <= S_ACK;
                end
                S_ACK:
                    if (!req)
                    begin
                        ack <= 1'b0;
                        state <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (state == S_IDLE && req)
        begin
            rd_addr.pad <= '0;
            rd_addr.image <= request.image;
            rd_addr.page <= (request.kind == LOAD_BOOT) ? BOOT_PAGE : request.page;
            rd_addr.offset <= '0;
        end
    end

endmodule

//--- design/bubble_loader_top.sv
`timescale 1ns/1ps

module bubble_loader_top (
    input  logic                  MCLK,
    input  logic                  rst_n,
    input  logic                  req,
    input  bubble_pkg::load_req_t request,
    output logic                  ack,
    output flash_pkg::spi_pins_t  spi,
    input  logic                  miso,
    output bubble_pkg::buf_wr_t   buf_wr
);
    import flash_pkg::*;

    logic        rd_start;
    logic        rd_stop;
    flash_addr_t rd_addr;
    logic        bit_req;
    logic        bit_valid;
    logic        bit_data;
    logic        map_clear;
    logic        map_wr_en;
    logic        map_wr_data;
    logic        map_rd_en;
    logic        map_rd_data;

    spi_flash_reader u_reader (
        .MCLK      (MCLK),
        .rst_n     (rst_n),
        .start     (rd_start),
        .stop      (rd_stop),
        .addr      (rd_addr),
        .bit_req   (bit_req),
        .bit_valid (bit_valid),
        .bit_data  (bit_data),
        .spi       (spi),
        .miso      (miso)
    );

    bad_loop_map u_map (
        .MCLK    (MCLK),
        .clear   (map_clear),
        .wr_en   (map_wr_en),
        .wr_data (map_wr_data),
        .rd_en   (map_rd_en),
        .rd_data (map_rd_data)
    );

    load_sequencer u_seq (
        .MCLK        (MCLK),
        .rst_n       (rst_n),
        .req         (req),
        .request     (request),
        .ack         (ack),
        .rd_start    (rd_start),
        .rd_stop     (rd_stop),
        .rd_addr     (rd_addr),
        .bit_req     (bit_req),
        .bit_valid   (bit_valid),
        .bit_data    (bit_data),
        .map_clear   (map_clear),
        .map_wr_en   (map_wr_en),
        .map_wr_data (map_wr_data),
        .map_rd_en   (map_rd_en),
        .map_rd_data (map_rd_data),
        .buf_wr      (buf_wr)
    );

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic MCLK,
    output logic rst_n
);
    localparam int HALF_PERIOD = 20;               // 40 ns clock
    localparam int RESET_CYCLES = 16;

    initial
    begin
        MCLK = 1'b0;
        forever #(HALF_PERIOD) MCLK = ~MCLK;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge MCLK);
        #2;
        rst_n = 1'b1;                              // released just after an edge
    end

endmodule

//--- bench/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
    input  flash_pkg::spi_pins_t            spi,
    output logic                            miso,
    output logic [flash_pkg::CMD_BITS-1:0]  cmd_word,
    output int                              cmd_count
);
    import flash_pkg::*;

    typedef logic [$bits(flash_addr_t)+2:0] bit_addr_t;

    int        cmd_cnt;                            // command bits since cs_n fell
    bit_addr_t bit_addr;                           // next bit to shift out

    // bootloader pages hold a fixed pattern, other pages an address pattern
    function automatic logic flash_bit(input bit_addr_t b);
        page_t pg;
        pg = b[OFFSET_W+3 +: PAGE_W];
        if (pg >= BOOT_PAGE && pg <= BOOT_PAGE + 12'd3)
            return b[3:0] != 4'd5;
        return b[1] ^ b[4];
    endfunction

    initial
    begin
        miso = 1'b0;
        cmd_word = '0;
        cmd_count = 0;
        cmd_cnt = 0;
        bit_addr = '0;
    end

    always @(posedge spi.cs_n or posedge spi.sck or negedge spi.sck)
    begin
        if (spi.cs_n)
            cmd_cnt = 0;                           // deselected, next command starts over
        else if (spi.sck)
        begin
            if (cmd_cnt < CMD_BITS)
            begin
                cmd_word = {cmd_word[CMD_BITS-2:0], spi.mosi};
                cmd_cnt++;
                if (cmd_cnt == CMD_BITS)
                begin
                    bit_addr = {cmd_word[$bits(flash_addr_t)-1:0], 3'b000};
                    cmd_count++;
                end
            end
        end
        else if (cmd_cnt == CMD_BITS)
        begin
            miso = flash_bit(bit_addr);            // data changes on the falling edge
            bit_addr++;
        end
    end

endmodule

//--- bench/bubble_loader_props.sv
`timescale 1ns/1ps

module bubble_loader_props (
    input logic                 MCLK,
    input logic                 rst_n,
    input logic                 req,
    input logic                 ack,
    input flash_pkg::spi_pins_t spi,
    input bubble_pkg::buf_wr_t  buf_wr
);
    int failures = 0;                              // polled by the testbench at the end

    wr_pulse_single: assert property (@(posedge MCLK) disable iff (!rst_n)
        buf_wr.en |=> !buf_wr.en)
    else
    begin
        failures++;
        $error("buffer write enable high for two cycles");
    end

    ack_needs_req: assert property (@(posedge MCLK) disable iff (!rst_n)
        $rose(ack) |-> req)
    else
    begin
        failures++;
        $error("ack rose while req was low");
    end

    sck_idle_high: assert property (@(posedge MCLK) disable iff (!rst_n)
        spi.cs_n |-> spi.sck)
    else
    begin
        failures++;
        $error("sck low while cs_n high");
    end

endmodule

bind bubble_loader_top bubble_loader_props props_i (
    .MCLK   (MCLK),
    .rst_n  (rst_n),
    .req    (req),
    .ack    (ack),
    .spi    (spi),
    .buf_wr (buf_wr)
);

//--- bench/tb_bubble_loader.sv
`timescale 1ns/1ps

module tb_bubble_loader;
    import flash_pkg::*;
    import bubble_pkg::*;

    typedef logic [$bits(flash_addr_t)+2:0] bit_addr_t;

    localparam int BOOT_CYCLES = 16000;            // 3856 bits at about 4 cycles each
    localparam int PAGE_CYCLES = 5000;
    localparam int TIMEOUT_CYCLES = 2 * (BOOT_CYCLES + 2 * PAGE_CYCLES) + 8000;

    logic                MCLK;
    logic                rst_n;
    logic                req;
    load_req_t           request;
    logic                ack;
    spi_pins_t           spi;
    logic                miso;
    buf_wr_t             buf_wr;
    logic [CMD_BITS-1:0] cmd_word;
    int                  cmd_count;

    logic        map_model [MAP_DEPTH];            // expected bad-loop table
    buf_wr_t     exp_q [$];
    logic [31:0] seed = 32'hc02a;
    int          cycles = 0;

    tb_clock_gen clk_gen_i (
        .MCLK  (MCLK),
        .rst_n (rst_n)
    );

    bubble_loader_top bubble_loader_top_i (
        .MCLK    (MCLK),
        .rst_n   (rst_n),
        .req     (req),
        .request (request),
        .ack     (ack),
        .spi     (spi),
        .miso    (miso),
        .buf_wr  (buf_wr)
    );

    spi_flash_model flash_i (
        .spi       (spi),
        .miso      (miso),
        .cmd_word  (cmd_word),
        .cmd_count (cmd_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic flash_bit(input bit_addr_t b);
        page_t pg;
        pg = b[OFFSET_W+3 +: PAGE_W];
        if (pg >= BOOT_PAGE && pg <= BOOT_PAGE + 12'd3)
            return b[3:0] != 4'd5;
        return b[1] ^ b[4];
    endfunction

    function automatic flash_addr_t read_addr(input image_t img, input page_t pg);
        flash_addr_t a;
        a.pad = 2'b00;
        a.image = img;
        a.page = pg;
        a.offset = '0;
        return a;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_buf_wr(input string name, input buf_wr_t got, input buf_wr_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s got en=%b addr=%0d data=%b, expected en=%b addr=%0d data=%b",
                     $time, name, got.en, got.addr, got.data, exp.en, exp.addr, exp.data);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cmd(input string name, input logic [CMD_BITS-1:0] got,
                             input logic [CMD_BITS-1:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // bootloader then error map, the map also lands in the table model
    task automatic expect_boot(input image_t img);
        bit_addr_t base;
        buf_wr_t   w;
        int        k;
        int        j;
        base = {read_addr(img, BOOT_PAGE), 3'b000};
        exp_q.delete();
        for (k = 0; k < BOOT_BITS + MAP_BITS; k++)
        begin
            w.en = 1'b1;
            w.addr = BOOT_BUF_BASE + buf_addr_t'(k);
            w.data = flash_bit(base + bit_addr_t'(k));
            exp_q.push_back(w);
            if (k >= BOOT_BITS)
            begin
                j = k - BOOT_BITS;
                map_model[(j / 16) * 16 + 15 - j % 16] = w.data;   // group of 16 reversed
            end
        end
    endtask

    task automatic expect_page(input image_t img, input page_t pg);
        bit_addr_t base;
        buf_wr_t   w;
        int        pos;
        int        good;
        base = {read_addr(img, pg), 3'b000};
        exp_q.delete();
        pos = 0;
        good = 0;
        w.en = 1'b1;
        while (good < PREAMBLE_BITS && pos < MAP_DEPTH)
        begin
            w.addr = PAGE_BUF_BASE + buf_addr_t'(pos);
            w.data = map_model[pos];               // good loop 1, bad loop 0
            if (map_model[pos])
                good++;
            exp_q.push_back(w);
            pos++;
        end
        good = 0;
        while (good < PAGE_BITS && pos < MAP_DEPTH)
        begin
            w.addr = PAGE_BUF_BASE + buf_addr_t'(pos);
            if (map_model[pos])
            begin
                w.data = flash_bit(base + bit_addr_t'(good));
                good++;
            end
            else
                w.data = 1'b0;                     // bad loop keeps the pending bit
            exp_q.push_back(w);
            pos++;
        end
    endtask

    task automatic send_request(input load_req_t r);
        @(posedge MCLK);
        #2;
        request = r;
        req = 1'b1;
    endtask

    task automatic collect_writes();
        int   idx;
        logic cs_before_ack;
        idx = 0;
        cs_before_ack = 1'b0;
        while (ack !== 1'b1)
        begin
            cs_before_ack = spi.cs_n;
            @(negedge MCLK);
            if (buf_wr.en === 1'b1)
            begin
                if (idx >= exp_q.size())
                begin
                    $display("ERROR: buffer write beyond the expected %0d writes", exp_q.size());
                    abort_run();
                end
                check_buf_wr("buf_wr", buf_wr, exp_q[idx]);
                idx++;
            end
        end
        if (idx != exp_q.size())
        begin
            $display("ERROR: load ended after %0d buffer writes instead of %0d",
                     idx, exp_q.size());
            abort_run();
        end
        check_bit("spi.cs_n", cs_before_ack, 1'b1); // flash deselected in the cycle before ack
        check_bit("spi.cs_n", spi.cs_n, 1'b1);
    endtask

    task automatic release_request();
        repeat (3)
        begin
            @(negedge MCLK);
            check_bit("ack", ack, 1'b1);
        end
        @(posedge MCLK);
        #2;
        req = 1'b0;
        @(posedge MCLK);                           // sequencer sees req low here
        @(negedge MCLK);
        check_bit("ack", ack, 1'b0);
    endtask

    task automatic run_load(input load_req_t r);
        flash_addr_t a;
        int          n_cmd;
        n_cmd = cmd_count;
        a = read_addr(r.image, (r.kind == LOAD_BOOT) ? BOOT_PAGE : r.page);
        send_request(r);
        collect_writes();
        if (cmd_count != n_cmd + 1)
        begin
            $display("ERROR: flash saw %0d read commands during one load", cmd_count - n_cmd);
            abort_run();
        end
        check_cmd("flash command", cmd_word, {READ_OPCODE, a});
        release_request();
    endtask

    task automatic test_idle_after_reset();
        repeat (8)
        begin
            @(negedge MCLK);
            check_bit("spi.cs_n", spi.cs_n, 1'b1);
            check_bit("spi.sck", spi.sck, 1'b1);
            check_bit("ack", ack, 1'b0);
            check_bit("buf_wr.en", buf_wr.en, 1'b0);
        end
    endtask

    task automatic test_boot_load();
        load_req_t r;
        seed = lcg_next(seed);
        r.kind = LOAD_BOOT;
        r.image = seed[18:16];
        r.page = seed[31:20];                      // page field ignored for boot
        $display("boot load, image %0d", r.image);
        expect_boot(r.image);
        run_load(r);
    endtask

    task automatic test_page_load();
        load_req_t r;
        seed = lcg_next(seed);
        r.kind = LOAD_PAGE;
        r.image = seed[18:16];
        r.page = seed[31:20];
        $display("page load, image %0d page %h", r.image, r.page);
        expect_page(r.image, r.page);
        run_load(r);
    endtask

    always @(posedge MCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: timeout, loads not finished after %0d clock cycles", cycles);
            abort_run();
        end
    end

    initial
    begin
        req = 1'b0;
        request = '0;
        foreach (map_model[a])
            map_model[a] = 1'b0;
        wait (rst_n === 1'b1);
        test_idle_after_reset();
        test_boot_load();
        test_page_load();
        test_page_load();                          // second handshake, new image and page
        if (bubble_loader_top_i.props_i.failures == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            $display("ERROR: %0d assertion failures", bubble_loader_top_i.props_i.failures);
            abort_run();
        end
    end

endmodule

//--- sim.f
common/flash_pkg.sv
common/bubble_pkg.sv
spi/spi_flash_reader.sv
design/bad_loop_map.sv
design/load_sequencer.sv
design/bubble_loader_top.sv
bench/tb_clock_gen.sv
bench/spi_flash_model.sv
bench/bubble_loader_props.sv
bench/tb_bubble_loader.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tb_bubble_loader
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing --assert --top-module $(TOP)
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG   = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
